/* hw/core_pkg.sv */
/*
 * core-wide types for the machine-mode CSR block: address and data words,
 * CSR addresses, command and cause encodings, CSR request/response structs
 */
package core_pkg;

    typedef logic [39:0] addr_t;      // virtual address
    typedef logic [63:0] bus64_t;     // data word
    typedef logic [11:0] csr_addr_t;  // csr address field

    // commands issued by the datapath
    typedef enum logic [2:0] {
        CSR_NONE = 3'd0,  // plain read, no side effect
        CSR_RW   = 3'd1,
        CSR_RS   = 3'd2,
        CSR_RC   = 3'd3,
        CSR_MRET = 3'd4
    } csr_cmd_e;

    // interrupt causes carry the top bit
    typedef enum logic [63:0] {
        CAUSE_ILLEGAL_INSN = 64'h0000_0000_0000_0002,
        CAUSE_M_TIMER      = 64'h8000_0000_0000_0007,
        CAUSE_M_EXT        = 64'h8000_0000_0000_000B
    } xcpt_cause_e;

    // ----------------------------------------
    // machine-mode csr map
    // ----------------------------------------
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MIP      = 12'h344;

    localparam addr_t MTVEC_RESET = 40'h00_0000_0100;  // trap vector out of reset

    // bit positions inside mstatus and mie/mip
    localparam int unsigned MSTATUS_MIE_BIT  = 3;
    localparam int unsigned MSTATUS_MPIE_BIT = 7;
    localparam int unsigned IRQ_TIMER_BIT    = 7;   // mtie / mtip
    localparam int unsigned IRQ_EXT_BIT      = 11;  // meie / meip

    // datapath -> csr, valid every cycle
    typedef struct packed {
        csr_addr_t rw_addr;
        csr_cmd_e  rw_cmd;
        bus64_t    rw_data;
        logic      exception;   // trap taken this cycle
        bus64_t    xcpt_cause;
        addr_t     pc;          // pc of the trapping instruction
        logic      retire;
    } req_cpu_csr_t;

    // csr -> datapath
    typedef struct packed {
        bus64_t rw_rdata;        // old value of the addressed csr
        logic   interrupt;
        bus64_t interrupt_cause;
        logic   exception;       // illegal csr access
        bus64_t exception_cause;
        bus64_t tval;
        logic   eret;
        addr_t  evec;            // redirect target
    } resp_csr_cpu_t;

endpackage

/* hw/pmu_pkg.sv */
/*
 * performance monitor definitions: event flags, counter count,
 * counter csr addresses and counter index
 */
package pmu_pkg;

    // one flag per countable event, from the datapath
    typedef struct packed {
        logic branch;
        logic branch_miss;
        logic load;
        logic store;
        logic stall;
    } pmu_event_t;

    localparam int unsigned HPM_EVENTS = 4;  // mhpmcounter3..6

    // counter csr addresses, index is the offset from mcycle
    localparam logic [11:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [11:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [11:0] CSR_MHPM_BASE = 12'hB03;

    typedef logic [2:0] hpm_idx_t;

    // index values seen by the counter block
    localparam hpm_idx_t HPM_IDX_MCYCLE   = 3'd0;
    localparam hpm_idx_t HPM_IDX_MINSTRET = 3'd2;
    localparam hpm_idx_t HPM_IDX_EVENT0   = 3'd3;  // first event counter

endpackage

/* hw/hpm_counters.sv */
/*
 * hardware performance monitor: mcycle, minstret and the event counters,
 * with a csr-side indexed read/write port
 */
module hpm_counters (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  pmu_pkg::hpm_idx_t   idx_i,      // offset from mcycle
    input  logic                we_i,
    input  core_pkg::bus64_t    wdata_i,
    input  logic                retire_i,
    input  pmu_pkg::pmu_event_t event_i,
    output core_pkg::bus64_t    rdata_o
);
    import core_pkg::*;
    import pmu_pkg::*;

    bus64_t                mcycle;
    bus64_t                minstret;
    bus64_t                hpm_cnt [HPM_EVENTS];
    logic [HPM_EVENTS-1:0] ev_inc;   // one increment per counter

    // mhpmcounter3..6 : branch, branch miss, load or store, stall
    assign ev_inc = {event_i.stall,
                     event_i.load | event_i.store,  // both high still counts once
                     event_i.branch_miss,
                     event_i.branch};

    // ----------------------------------------
    // counters, a write replaces the increment
    // ----------------------------------------
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            mcycle   <= '0;
            minstret <= '0;
            for (int i = 0; i < HPM_EVENTS; i++) begin
                hpm_cnt[i] <= '0;
            end
        end else begin
            if (we_i && idx_i == HPM_IDX_MCYCLE) mcycle <= wdata_i;
            else                                 mcycle <= mcycle + 64'd1;

            if (we_i && idx_i == HPM_IDX_MINSTRET) minstret <= wdata_i;
            else if (retire_i)                     minstret <= minstret + 64'd1;

            for (int i = 0; i < HPM_EVENTS; i++) begin
                if (we_i && idx_i == hpm_idx_t'(HPM_IDX_EVENT0 + i)) begin
                    hpm_cnt[i] <= wdata_i;
                end else if (ev_inc[i]) begin
                    hpm_cnt[i] <= hpm_cnt[i] + 64'd1;
                end
            end
        end
    end

    // read mux, unused indexes read zero
    always_comb begin
        rdata_o = '0;
        if (idx_i == HPM_IDX_MCYCLE)   rdata_o = mcycle;
        if (idx_i == HPM_IDX_MINSTRET) rdata_o = minstret;
        for (int i = 0; i < HPM_EVENTS; i++) begin
            if (idx_i == hpm_idx_t'(HPM_IDX_EVENT0 + i)) rdata_o = hpm_cnt[i];
        end
    end

    // the csr side never writes past the last event counter
    a_we_idx: assert property (@(posedge clk_i) disable iff (!rstn_i)
        we_i |-> idx_i < HPM_EVENTS + 3);

endmodule

/* hw/csr_unit.sv */
/*
 * machine-mode csr file: read/write/set/clear decode, illegal access check,
 * trap entry and mret, timer/external interrupt request; counter csrs go to the hpm
 */
module csr_unit (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  core_pkg::req_cpu_csr_t req_i,
    input  logic                   time_irq_i,    // timer level
    input  logic                   irq_i,         // external level
    input  core_pkg::bus64_t       perf_rdata_i,  // indexed counter value
    output core_pkg::resp_csr_cpu_t resp_o,
    output pmu_pkg::hpm_idx_t      perf_idx_o,
    output logic                   perf_we_o,
    output core_pkg::bus64_t       perf_wdata_o
);
    import core_pkg::*;
    import pmu_pkg::*;

    // machine state, only implemented bits are kept
    logic   mstatus_mie, mstatus_mpie;
    logic   mie_mtie, mie_meie;
    addr_t  mtvec;
    bus64_t mscratch;
    addr_t  mepc;
    bus64_t mcause;
    bus64_t mtval;

    logic   hit_cnt;     // address falls in the counter window
    logic   known;       // address decodes to something
    logic   is_wr_cmd;   // rw/rs/rc
    logic   illegal;
    logic   wr_en;       // write really happens this cycle
    logic   do_mret;
    bus64_t csr_rdata;   // old value
    bus64_t csr_wdata;   // value after the command
    logic   irq_ext, irq_tim;

    // ----------------------------------------
    // address decode and old value
    // ----------------------------------------
    assign hit_cnt = (req_i.rw_addr == CSR_MCYCLE) || (req_i.rw_addr == CSR_MINSTRET) ||
                     ((req_i.rw_addr >= CSR_MHPM_BASE) &&
                      (req_i.rw_addr < CSR_MHPM_BASE + HPM_EVENTS));

    always_comb begin
        known     = 1'b1;
        csr_rdata = '0;
        case (req_i.rw_addr)
            CSR_MSTATUS: begin
                csr_rdata[MSTATUS_MIE_BIT]  = mstatus_mie;
                csr_rdata[MSTATUS_MPIE_BIT] = mstatus_mpie;
            end
            CSR_MIE: begin
                csr_rdata[IRQ_TIMER_BIT] = mie_mtie;
                csr_rdata[IRQ_EXT_BIT]   = mie_meie;
            end
            CSR_MIP: begin                              // live input levels
                csr_rdata[IRQ_TIMER_BIT] = time_irq_i;
                csr_rdata[IRQ_EXT_BIT]   = irq_i;
            end
            CSR_MTVEC:    csr_rdata = {24'b0, mtvec};
            CSR_MSCRATCH: csr_rdata = mscratch;
            CSR_MEPC:     csr_rdata = {24'b0, mepc};
            CSR_MCAUSE:   csr_rdata = mcause;
            CSR_MTVAL:    csr_rdata = mtval;
            default: begin
                if (hit_cnt) csr_rdata = perf_rdata_i;  // counter read comes back same cycle
                else         known     = 1'b0;
            end
        endcase
    end

    // rw/rs/rc result
    always_comb begin
        case (req_i.rw_cmd)
            CSR_RW:  csr_wdata = req_i.rw_data;
            CSR_RS:  csr_wdata = csr_rdata | req_i.rw_data;
            CSR_RC:  csr_wdata = csr_rdata & ~req_i.rw_data;
            default: csr_wdata = csr_rdata;
        endcase
    end

    assign is_wr_cmd = (req_i.rw_cmd == CSR_RW) || (req_i.rw_cmd == CSR_RS) ||
                       (req_i.rw_cmd == CSR_RC);
    assign illegal   = is_wr_cmd && !known;
    assign wr_en     = is_wr_cmd && known && !req_i.exception;  // trap drops the write
    assign do_mret   = (req_i.rw_cmd == CSR_MRET) && !req_i.exception;

    // counter port
    assign perf_idx_o   = hit_cnt ? hpm_idx_t'(req_i.rw_addr - CSR_MCYCLE) : '0;
    assign perf_we_o    = wr_en && hit_cnt;
    assign perf_wdata_o = csr_wdata;

    // ----------------------------------------
    // machine register update
    // ----------------------------------------
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_mtie     <= 1'b0;
            mie_meie     <= 1'b0;
            mtvec        <= MTVEC_RESET;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
        end else if (req_i.exception) begin    // trap entry wins
            mepc         <= req_i.pc;
            mcause       <= req_i.xcpt_cause;
            mtval        <= '0;
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
        end else if (do_mret) begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end else if (wr_en) begin
            case (req_i.rw_addr)
                CSR_MSTATUS: begin
                    mstatus_mie  <= csr_wdata[MSTATUS_MIE_BIT];
                    mstatus_mpie <= csr_wdata[MSTATUS_MPIE_BIT];
                end
                CSR_MIE: begin
                    mie_mtie <= csr_wdata[IRQ_TIMER_BIT];
                    mie_meie <= csr_wdata[IRQ_EXT_BIT];
                end
                CSR_MTVEC:    mtvec    <= csr_wdata[39:0];
                CSR_MSCRATCH: mscratch <= csr_wdata;
                CSR_MEPC:     mepc     <= csr_wdata[39:0];
                CSR_MCAUSE:   mcause   <= csr_wdata;
                CSR_MTVAL:    mtval    <= csr_wdata;
                default: ;                             // mip read-only, counters in hpm
            endcase
        end
    end

    // ----------------------------------------
    // interrupts and response
    // ----------------------------------------
    assign irq_ext = mstatus_mie && mie_meie && irq_i;
    assign irq_tim = mstatus_mie && mie_mtie && time_irq_i;

    always_comb begin
        resp_o.rw_rdata  = csr_rdata;
        resp_o.interrupt = irq_ext || irq_tim;
        if (irq_ext)      resp_o.interrupt_cause = CAUSE_M_EXT;  // external first
        else if (irq_tim) resp_o.interrupt_cause = CAUSE_M_TIMER;
        else              resp_o.interrupt_cause = '0;
        resp_o.exception       = illegal;
        resp_o.exception_cause = illegal ? bus64_t'(CAUSE_ILLEGAL_INSN) : '0;
        resp_o.tval            = illegal ? {52'b0, req_i.rw_addr} : '0;
        resp_o.eret            = do_mret;
        resp_o.evec            = do_mret ? mepc : mtvec;  // trap target otherwise
    end

    // the datapath never traps on an mret request
    a_xcpt_eret: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(req_i.exception && (req_i.rw_cmd == CSR_MRET)));

    // counter writes only reach implemented counters
    a_perf_idx: assert property (@(posedge clk_i) disable iff (!rstn_i)
        perf_we_o |-> (perf_idx_o != 3'd1) && (perf_idx_o < HPM_EVENTS + 3));

endmodule

/* hw/core_csr_top.sv */
/*
 * control/status top: machine csr file plus performance counters,
 * between the datapath request and the csr response
 */
module core_csr_top (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  core_pkg::req_cpu_csr_t  req_csr_i,    // valid every cycle
    input  pmu_pkg::pmu_event_t     pmu_event_i,
    input  logic                    time_irq_i,   // timer interrupt level
    input  logic                    irq_i,        // external interrupt level
    output core_pkg::resp_csr_cpu_t resp_csr_o
);
    import core_pkg::*;
    import pmu_pkg::*;

    // csr file <-> counter block
    hpm_idx_t perf_idx;
    logic     perf_we;
    bus64_t   perf_wdata;
    bus64_t   perf_rdata;   // combinational read back

    // ----------------------------------------
    // machine csr file
    // ----------------------------------------
    csr_unit i_csr (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .req_i        (req_csr_i),
        .time_irq_i   (time_irq_i),
        .irq_i        (irq_i),
        .perf_rdata_i (perf_rdata),
        .resp_o       (resp_csr_o),
        .perf_idx_o   (perf_idx),
        .perf_we_o    (perf_we),
        .perf_wdata_o (perf_wdata)
    );

    // performance counters, retire taken straight from the request
    hpm_counters i_hpm (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .idx_i    (perf_idx),
        .we_i     (perf_we),
        .wdata_i  (perf_wdata),
        .retire_i (req_csr_i.retire),
        .event_i  (pmu_event_i),
        .rdata_o  (perf_rdata)
    );

endmodule

/* bench/tb_ref.svh */
/*
 * reference model of the csr block: register and counter state,
 * read, command, response and per-cycle update functions, galois lfsr
 */

// ----------------------------------------
// model state
// ----------------------------------------
logic        m_mie, m_mpie;       // mstatus bits
logic        m_mtie, m_meie;      // mie bits
addr_t       m_mtvec;
bus64_t      m_mscratch;
addr_t       m_mepc;
bus64_t      m_mcause;
bus64_t      m_mtval;
bus64_t      m_mcycle;
bus64_t      m_minstret;
bus64_t      m_hpm [HPM_EVENTS];  // branch, miss, load/store, stall
logic [31:0] lfsr_q = 32'd8;      // seed

function automatic void ref_reset();
    m_mie      = 1'b0;
    m_mpie     = 1'b0;
    m_mtie     = 1'b0;
    m_meie     = 1'b0;
    m_mtvec    = MTVEC_RESET;
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mtval    = '0;
    m_mcycle   = '0;
    m_minstret = '0;
    for (int i = 0; i < HPM_EVENTS; i++) begin
        m_hpm[i] = '0;
    end
endfunction

// every implemented csr, counter window included
function automatic logic ref_known(input csr_addr_t a);
    return (a inside {CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC,
                      CSR_MCAUSE, CSR_MTVAL, CSR_MIP, CSR_MCYCLE, CSR_MINSTRET}) ||
           ((a - CSR_MHPM_BASE) < 12'(HPM_EVENTS));  // wraps below the base
endfunction

function automatic bus64_t ref_read(input csr_addr_t a, input logic tirq, input logic eirq);
    bus64_t v;
    v = '0;
    case (a)
        CSR_MSTATUS: begin
            v[MSTATUS_MIE_BIT]  = m_mie;
            v[MSTATUS_MPIE_BIT] = m_mpie;
        end
        CSR_MIE: begin
            v[IRQ_TIMER_BIT] = m_mtie;
            v[IRQ_EXT_BIT]   = m_meie;
        end
        CSR_MIP: begin                          // live levels
            v[IRQ_TIMER_BIT] = tirq;
            v[IRQ_EXT_BIT]   = eirq;
        end
        CSR_MTVEC:    v = {24'b0, m_mtvec};
        CSR_MSCRATCH: v = m_mscratch;
        CSR_MEPC:     v = {24'b0, m_mepc};
        CSR_MCAUSE:   v = m_mcause;
        CSR_MTVAL:    v = m_mtval;
        CSR_MCYCLE:   v = m_mcycle;
        CSR_MINSTRET: v = m_minstret;
        default: begin
            if (ref_known(a)) v = m_hpm[int'(a - CSR_MHPM_BASE)];
        end
    endcase
    return v;
endfunction

function automatic bus64_t ref_cmd(input csr_cmd_e c, input bus64_t old_v, input bus64_t d);
    case (c)
        CSR_RW:  return d;
        CSR_RS:  return old_v | d;
        CSR_RC:  return old_v & ~d;
        default: return old_v;
    endcase
endfunction

// expected response for the request of this cycle
function automatic resp_csr_cpu_t ref_resp(input req_cpu_csr_t r, input logic tirq,
                                           input logic eirq);
    resp_csr_cpu_t e;
    logic          is_wr;
    logic          ext;
    logic          tim;
    e     = '0;
    is_wr = r.rw_cmd inside {CSR_RW, CSR_RS, CSR_RC};
    ext   = m_mie && m_meie && eirq;
    tim   = m_mie && m_mtie && tirq;
    e.rw_rdata  = ref_read(r.rw_addr, tirq, eirq);
    e.interrupt = ext || tim;
    if (ext)      e.interrupt_cause = CAUSE_M_EXT;    // external before timer
    else if (tim) e.interrupt_cause = CAUSE_M_TIMER;
    if (is_wr && !ref_known(r.rw_addr)) begin
        e.exception       = 1'b1;
        e.exception_cause = CAUSE_ILLEGAL_INSN;
        e.tval            = {52'b0, r.rw_addr};
    end
    e.eret = (r.rw_cmd == CSR_MRET) && !r.exception;
    e.evec = e.eret ? m_mepc : m_mtvec;
    return e;
endfunction

// state after the coming rising edge
function automatic void ref_step(input req_cpu_csr_t r, input pmu_event_t ev,
                                 input logic tirq, input logic eirq);
    bus64_t old_v;
    bus64_t new_v;
    logic   is_wr;
    old_v = ref_read(r.rw_addr, tirq, eirq);
    new_v = ref_cmd(r.rw_cmd, old_v, r.rw_data);
    is_wr = r.rw_cmd inside {CSR_RW, CSR_RS, CSR_RC};
    m_mcycle   = m_mcycle + 64'd1;
    m_minstret = m_minstret + 64'(r.retire);
    m_hpm[0]   = m_hpm[0] + 64'(ev.branch);
    m_hpm[1]   = m_hpm[1] + 64'(ev.branch_miss);
    m_hpm[2]   = m_hpm[2] + 64'(ev.load | ev.store);  // once for both
    m_hpm[3]   = m_hpm[3] + 64'(ev.stall);
    if (r.exception) begin
        m_mepc   = r.pc;
        m_mcause = r.xcpt_cause;
        m_mtval  = '0;
        m_mpie   = m_mie;
        m_mie    = 1'b0;
    end else if (r.rw_cmd == CSR_MRET) begin
        m_mie  = m_mpie;
        m_mpie = 1'b1;
    end else if (is_wr && ref_known(r.rw_addr)) begin
        case (r.rw_addr)
            CSR_MSTATUS: begin
                m_mie  = new_v[MSTATUS_MIE_BIT];
                m_mpie = new_v[MSTATUS_MPIE_BIT];
            end
            CSR_MIE: begin
                m_mtie = new_v[IRQ_TIMER_BIT];
                m_meie = new_v[IRQ_EXT_BIT];
            end
            CSR_MTVEC:    m_mtvec    = new_v[39:0];
            CSR_MSCRATCH: m_mscratch = new_v;
            CSR_MEPC:     m_mepc     = new_v[39:0];
            CSR_MCAUSE:   m_mcause   = new_v;
            CSR_MTVAL:    m_mtval    = new_v;
            CSR_MCYCLE:   m_mcycle   = new_v;        // write replaces the increment
            CSR_MINSTRET: m_minstret = new_v;
            CSR_MIP:      ;                          // read-only
            default:      m_hpm[int'(r.rw_addr - CSR_MHPM_BASE)] = new_v;
        endcase
    end
endfunction

// ----------------------------------------
// random source
// ----------------------------------------
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);  // right shifting galois
endfunction

// one lfsr step per bit taken
function automatic bus64_t rand_bits(input int n);
    bus64_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        v      = {v[62:0], lfsr_q[0]};
    end
    return v;
endfunction

/* bench/tb_core_csr.sv */
/*
 * testbench for core_csr_top: clock and reset, stimulus sequences,
 * response checker against the reference model, timeout
 */
module tb_core_csr;
    import core_pkg::*;
    import pmu_pkg::*;

    // cycles per sequence
    localparam int T_RESET = 3;
    localparam int T_INIT  = 8 + 16 + 1;
    localparam int T_RW    = 2 * 40;
    localparam int T_ILL   = 16 + 8;
    localparam int T_TRAP  = 4 * 9;
    localparam int T_IRQ   = 2 + 30 + 1 + 20;
    localparam int T_PMU   = 200;
    localparam int T_TAIL  = 3;
    localparam int TIMEOUT_CYCLES =
        2 * (T_RESET + T_INIT + T_RW + T_ILL + T_TRAP + T_IRQ + T_PMU + T_TAIL);

    logic          clk_i;
    logic          rstn_i;
    req_cpu_csr_t  req_csr_i;
    pmu_event_t    pmu_event_i;
    logic          time_irq_i;
    logic          irq_i;
    resp_csr_cpu_t resp_csr_o;
    resp_csr_cpu_t exp_resp;       // model response of the current cycle
    int            cycle_cnt = 0;

    `include "tb_ref.svh"

    core_csr_top i_dut (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .req_csr_i   (req_csr_i),
        .pmu_event_i (pmu_event_i),
        .time_irq_i  (time_irq_i),
        .irq_i       (irq_i),
        .resp_csr_o  (resp_csr_o)
    );

    always #10 clk_i = ~clk_i;  // period 20

    // ----------------------------------------
    // failure handling and compare tasks
    // ----------------------------------------
    task automatic stop_on_failure();
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_data(input string name, input bus64_t got, input bus64_t exp);
        if (got !== exp) begin
            $display("** Error @ %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            $display("** Error @ %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error @ %0t: %s is %b, expected %b", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    // inputs are stable at the falling edge, model steps after the compare
    always @(negedge clk_i) begin
        if (rstn_i !== 1'b1) begin
            ref_reset();
        end else begin
            exp_resp = ref_resp(req_csr_i, time_irq_i, irq_i);
            check_data("rw_rdata", resp_csr_o.rw_rdata, exp_resp.rw_rdata);
            check_flag("interrupt", resp_csr_o.interrupt, exp_resp.interrupt);
            check_data("interrupt_cause", resp_csr_o.interrupt_cause,
                       exp_resp.interrupt_cause);
            check_flag("exception", resp_csr_o.exception, exp_resp.exception);
            check_data("exception_cause", resp_csr_o.exception_cause,
                       exp_resp.exception_cause);
            check_data("tval", resp_csr_o.tval, exp_resp.tval);
            check_flag("eret", resp_csr_o.eret, exp_resp.eret);
            check_addr("evec", resp_csr_o.evec, exp_resp.evec);
            ref_step(req_csr_i, pmu_event_i, time_irq_i, irq_i);
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not end within %0d clock cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    task automatic drive(input req_cpu_csr_t r, input pmu_event_t ev,
                         input logic tirq, input logic eirq);
        @(posedge clk_i);
        req_csr_i   <= r;
        pmu_event_i <= ev;
        time_irq_i  <= tirq;
        irq_i       <= eirq;
    endtask

    // plain csr command, no events, levels low
    task automatic access(input csr_cmd_e c, input csr_addr_t a, input bus64_t d);
        req_cpu_csr_t r;
        r         = '0;
        r.rw_cmd  = c;
        r.rw_addr = a;
        r.rw_data = d;
        drive(r, '0, 1'b0, 1'b0);
    endtask

    function automatic csr_cmd_e pick_cmd();
        bus64_t v;
        v = rand_bits(2);
        case (v[1:0])
            2'd0:    return CSR_RW;
            2'd1:    return CSR_RS;
            default: return CSR_RC;
        endcase
    endfunction

    function automatic csr_addr_t csr_at(input int k);
        case (k)
            0:       return CSR_MSTATUS;
            1:       return CSR_MIE;
            2:       return CSR_MTVEC;
            3:       return CSR_MSCRATCH;
            4:       return CSR_MEPC;
            5:       return CSR_MCAUSE;
            6:       return CSR_MTVAL;
            default: return CSR_MIP;
        endcase
    endfunction

    // 0 is minstret, 1..4 the event counters
    function automatic csr_addr_t cnt_addr(input int k);
        return (k == 0) ? CSR_MINSTRET : CSR_MHPM_BASE + 12'(k - 1);
    endfunction

    // ----------------------------------------
    // sequences
    // ----------------------------------------
    task automatic reset_reads();
        bus64_t v;
        for (int k = 0; k < 8; k++) begin
            access(CSR_NONE, csr_at(k), '0);
        end
        v = rand_bits(4);
        for (int k = 0; k <= int'(v[3:0]); k++) begin
            access(CSR_NONE, CSR_MSCRATCH, '0);
        end
        access(CSR_NONE, CSR_MCYCLE, '0);
    endtask

    task automatic random_rw();
        bus64_t    v;
        csr_addr_t a;
        for (int i = 0; i < 40; i++) begin
            v = rand_bits(2);
            case (v[1:0])
                2'd0:    a = CSR_MSCRATCH;
                2'd1:    a = CSR_MTVEC;
                default: a = CSR_MIE;
            endcase
            access(pick_cmd(), a, rand_bits(64));  // old value back
            access(CSR_NONE, a, '0);               // new value
        end
    endtask

    task automatic illegal_access();
        bus64_t v;
        for (int i = 0; i < 16; i++) begin
            v = rand_bits(12);
            while (ref_known(v[11:0])) v = rand_bits(12);
            access(pick_cmd(), v[11:0], rand_bits(64));
        end
        for (int k = 0; k < 8; k++) begin
            access(CSR_NONE, csr_at(k), '0);
        end
    endtask

    task automatic trap_and_mret();
        req_cpu_csr_t r;
        bus64_t       v;
        for (int i = 0; i < 4; i++) begin
            access(CSR_RW, CSR_MSTATUS, rand_bits(64) & 64'h88);  // random mie/mpie
            r            = '0;
            r.exception  = 1'b1;
            v            = rand_bits(40);
            r.pc         = v[39:0];
            r.xcpt_cause = rand_bits(64);
            r.rw_cmd     = CSR_RW;           // dropped under the trap
            r.rw_addr    = CSR_MSCRATCH;
            r.rw_data    = rand_bits(64);
            drive(r, '0, 1'b0, 1'b0);
            access(CSR_NONE, CSR_MEPC, '0);
            access(CSR_NONE, CSR_MCAUSE, '0);
            access(CSR_NONE, CSR_MTVAL, '0);
            access(CSR_NONE, CSR_MSTATUS, '0);
            access(CSR_NONE, CSR_MSCRATCH, '0);
            access(CSR_MRET, CSR_MSTATUS, '0);
            access(CSR_NONE, CSR_MSTATUS, '0);
        end
    endtask

    task automatic irq_levels();
        req_cpu_csr_t r;
        bus64_t       v;
        r         = '0;
        r.rw_addr = CSR_MIP;
        access(CSR_RW, CSR_MIE, 64'h880);    // mtie and meie
        access(CSR_RW, CSR_MSTATUS, 64'h8);  // global enable
        for (int i = 0; i < 30; i++) begin
            v = rand_bits(2);
            drive(r, '0, v[0], v[1]);
        end
        access(CSR_RC, CSR_MSTATUS, 64'h8);  // interrupt must stay low now
        for (int i = 0; i < 20; i++) begin
            v = rand_bits(2);
            drive(r, '0, v[0], v[1]);
        end
    endtask

    task automatic counter_stream();
        req_cpu_csr_t r;
        pmu_event_t   ev;
        bus64_t       v;
        csr_addr_t    wr_addr;
        v       = rand_bits(3);
        wr_addr = cnt_addr(int'(v[2:0]) % 5);
        for (int c = 0; c < 200; c++) begin
            v         = rand_bits(6);
            ev        = v[4:0];
            r         = '0;
            r.retire  = v[5];
            r.rw_cmd  = CSR_NONE;
            r.rw_addr = (c == 101) ? wr_addr : cnt_addr(c % 5);  // read back the write
            if (c == 100) begin
                r.rw_cmd  = CSR_RW;
                r.rw_addr = wr_addr;
                r.rw_data = rand_bits(64);
            end
            drive(r, ev, 1'b0, 1'b0);
        end
    endtask

    initial begin
        clk_i       = 1'b0;
        rstn_i      = 1'b0;
        req_csr_i   = '0;
        pmu_event_i = '0;
        time_irq_i  = 1'b0;
        irq_i       = 1'b0;
        repeat (T_RESET) @(posedge clk_i);
        rstn_i <= 1'b1;
        reset_reads();
        random_rw();
        illegal_access();
        trap_and_mret();
        irq_levels();
        counter_stream();
        access(CSR_NONE, CSR_MSCRATCH, '0);
        access(CSR_NONE, CSR_MSCRATCH, '0);
        @(posedge clk_i);  // last request checked at the falling edge before
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* tb.f */
+incdir+bench
hw/core_pkg.sv
hw/pmu_pkg.sv
hw/hpm_counters.sv
hw/csr_unit.sv
hw/core_csr_top.sv
bench/tb_core_csr.sv

/* Makefile */
# Verilator build and run of the CSR block testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_core_csr
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run, and check $(LOG) for a failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	elif ! grep -q "STATUS: PASS" $(LOG); then \
		echo "no result in $(LOG)"; exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
